/* hw/control_pulse_gen.sv */
`timescale 1ns/10ps

module control_pulse_gen #(
    parameter int FRAME_OFFSET = timing_cfg_pkg::frame_offset_default
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clk_64khz,
    input  logic                          imu_int_n,
    output logic                          imu_clkin,
    output timing_types_pkg::ctrl_ticks_t ticks
);

    import timing_cfg_pkg::*;

    logic reset_64khz;
    logic imu_clk_q;

    logic [2:0]              imu_clk_sync;
    logic                    imu_clk_rise;
    logic                    int_n_prev;
    logic                    int_fall;
    logic                    frame_hit;
    logic [tick_count_w-1:0] phase_cnt;
    logic [sub_count_w-1:0]  sub_cnt;

    reset_sync i_reset_sync (
        .clk       (clk_64khz),
        .reset_in  (reset),
        .reset_out (reset_64khz)
    );

    // toggle divider for the imu sample clock.
    always_ff @(posedge clk_64khz or posedge reset_64khz) begin
        if (reset_64khz) begin
            imu_clk_q <= 1'b0;
        end else begin
            imu_clk_q <= ~imu_clk_q;
        end
    end

    assign imu_clkin = imu_clk_q;

    // a tick is a synchronized rising edge of the imu clock.
    assign imu_clk_rise = imu_clk_sync[1] & ~imu_clk_sync[2];

    // the active-low interrupt re-aligns the phase on its falling edge.
    assign int_fall  = ~imu_int_n & int_n_prev;
    assign frame_hit = (phase_cnt == tick_count_w'(FRAME_OFFSET));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            imu_clk_sync <= '0;
            int_n_prev   <= 1'b1;
            phase_cnt    <= '0;
            sub_cnt      <= '0;
            ticks        <= '0;
        end else begin
            imu_clk_sync <= {imu_clk_sync[1:0], imu_clk_q};
            if (imu_clk_rise) begin
                int_n_prev <= imu_int_n;

                if (int_fall) begin
                    phase_cnt <= '0;
                end else begin
                    phase_cnt <= phase_cnt + 1'b1;
                end

                if (frame_hit) begin
                    sub_cnt <= '0;
                end else begin
                    sub_cnt <= sub_cnt + 1'b1;
                end

                ticks.tick     <= 1'b1;
                ticks.int_edge <= int_fall;
                ticks.frame    <= frame_hit;
                ticks.sub      <= &sub_cnt;
            end else begin
                ticks <= '0;
            end
        end
    end

endmodule

/* hw/control_timing_top.sv */
`timescale 1ns/10ps

module control_timing_top #(
    parameter int FRAME_OFFSET = timing_cfg_pkg::frame_offset_default,
    parameter int SYNC_TIMEOUT = timing_cfg_pkg::sync_timeout_default
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           clk_64khz,
    input  logic                           imu_int_n,
    output logic                           imu_clkin,
    output timing_types_pkg::ctrl_ticks_t  ticks,
    output timing_types_pkg::frame_stamp_t stamp,
    output timing_types_pkg::sync_status_t sync
);

    // tick strobes and imu clock.
    control_pulse_gen #(
        .FRAME_OFFSET (FRAME_OFFSET)
    ) i_control_pulse_gen (
        .clk       (clk),
        .reset     (reset),
        .clk_64khz (clk_64khz),
        .imu_int_n (imu_int_n),
        .imu_clkin (imu_clkin),
        .ticks     (ticks)
    );

    imu_sync_monitor #(
        .SYNC_TIMEOUT (SYNC_TIMEOUT)
    ) i_imu_sync_monitor (
        .clk   (clk),
        .reset (reset),
        .ticks (ticks),
        .sync  (sync)
    );

    frame_sequencer i_frame_sequencer (
        .clk   (clk),
        .reset (reset),
        .ticks (ticks),
        .stamp (stamp)
    );

endmodule

/* hw/frame_sequencer.sv */
`timescale 1ns/10ps

module frame_sequencer (
    input  logic                           clk,
    input  logic                           reset,
    input  timing_types_pkg::ctrl_ticks_t  ticks,
    output timing_types_pkg::frame_stamp_t stamp
);

    import timing_cfg_pkg::*;

    logic [frame_num_w-1:0] frame_num;
    logic [frame_num_w-1:0] next_frame;
    logic [sub_count_w-1:0] sub_index;
    logic                   started;

    // first frame after reset is number 0.
    assign next_frame = started ? frame_num + 1'b1 : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_num <= '0;
            sub_index <= '0;
            started   <= 1'b0;
            stamp     <= '0;
        end else begin
            stamp.valid <= ticks.frame | ticks.sub;

            // frame wins when both strobes land together.
            if (ticks.frame) begin
                frame_num       <= next_frame;
                sub_index       <= '0;
                started         <= 1'b1;
                stamp.is_frame  <= 1'b1;
                stamp.frame_num <= next_frame;
                stamp.sub_index <= '0;
            end else if (ticks.sub) begin
                sub_index       <= sub_index + 1'b1;
                stamp.is_frame  <= 1'b0;
                stamp.frame_num <= frame_num;
                stamp.sub_index <= sub_index + 1'b1;
            end
        end
    end

endmodule

/* hw/imu_sync_monitor.sv */
`timescale 1ns/10ps

module imu_sync_monitor #(
    parameter int SYNC_TIMEOUT = timing_cfg_pkg::sync_timeout_default
) (
    input  logic                           clk,
    input  logic                           reset,
    input  timing_types_pkg::ctrl_ticks_t  ticks,
    output timing_types_pkg::sync_status_t sync
);

    localparam int count_w = $clog2(SYNC_TIMEOUT + 1);

    logic [count_w-1:0] since_int;
    logic               timeout_hit;

    // the tick that brings the count up to the timeout.
    assign timeout_hit = ticks.tick && !ticks.int_edge &&
                         (since_int == count_w'(SYNC_TIMEOUT - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            since_int <= '0;
            sync      <= '0;
        end else begin
            sync.lost_strobe <= 1'b0;

            if (ticks.int_edge) begin
                since_int   <= '0;
                sync.locked <= 1'b1;
            end else if (ticks.tick && (since_int != count_w'(SYNC_TIMEOUT))) begin
                since_int <= since_int + 1'b1;
            end

            // count holds at the timeout, so this fires once per gap.
            if (timeout_hit && sync.locked) begin
                sync.locked      <= 1'b0;
                sync.lost_strobe <= 1'b1;
                if (!(&sync.lost_count)) begin
                    sync.lost_count <= sync.lost_count + 1'b1;
                end
            end
        end
    end

endmodule

/* hw/reset_sync.sv */
`timescale 1ns/10ps

module reset_sync (
    input  logic clk,
    input  logic reset_in,
    output logic reset_out
);

    logic [1:0] sync_ff;

    // assert at once, release after two local clock edges.
    always_ff @(posedge clk or posedge reset_in) begin
        if (reset_in) begin
            sync_ff <= 2'b11;
        end else begin
            sync_ff <= {sync_ff[0], 1'b0};
        end
    end

    assign reset_out = sync_ff[1];

endmodule

/* hw/timing_cfg_pkg.sv */
package timing_cfg_pkg;

    // ticks from the interrupt tick to the frame strobe.
    parameter int frame_offset_default = 5;

    // the tick phase counter wraps every 64 ticks.
    parameter int tick_count_w = 6;

    // one subframe strobe every 8 ticks.
    parameter int sub_count_w = 3;

    // ticks without an interrupt before sync is lost.
    parameter int sync_timeout_default = 40;

    parameter int frame_num_w = 16;

endpackage

/* hw/timing_types_pkg.sv */
package timing_types_pkg;

    // one-cycle strobes in the clk domain.
    typedef struct packed {
        logic tick;
        logic int_edge;
        logic frame;
        logic sub;
    } ctrl_ticks_t;

    // the frame stamp is valid for one cycle per frame or subframe strobe.
    typedef struct packed {
        logic                                    valid;
        logic                                    is_frame;
        logic [timing_cfg_pkg::frame_num_w-1:0] frame_num;
        logic [timing_cfg_pkg::sub_count_w-1:0] sub_index;
    } frame_stamp_t;

    // imu sync state and lost-sync bookkeeping.
    typedef struct packed {
        logic       locked;
        logic       lost_strobe;
        logic [7:0] lost_count;
    } sync_status_t;

endpackage

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f verilog.f --top-module control_timing_tb \
    -o control_timing_sim > sim.log 2>&1 \
    && ./obj_dir/control_timing_sim >> sim.log 2>&1 \
    || echo "build or simulation returned an error" >> sim.log

grep -q "Finished with no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* test/control_timing_props.sv */
`timescale 1ns/10ps

module control_timing_props (
    input logic                           clk,
    input logic                           reset,
    input logic                           imu_clkin,
    input timing_types_pkg::ctrl_ticks_t  ticks,
    input timing_types_pkg::frame_stamp_t stamp,
    input timing_types_pkg::sync_status_t sync
);

    // every strobe lasts a single clk cycle.
    tick_one_cycle: assert property (@(posedge clk) disable iff (reset)
        ticks.tick |=> !ticks.tick)
        else $error("ticks.tick held for more than one cycle");

    int_edge_one_cycle: assert property (@(posedge clk) disable iff (reset)
        ticks.int_edge |=> !ticks.int_edge)
        else $error("ticks.int_edge held for more than one cycle");

    frame_one_cycle: assert property (@(posedge clk) disable iff (reset)
        ticks.frame |=> !ticks.frame)
        else $error("ticks.frame held for more than one cycle");

    sub_one_cycle: assert property (@(posedge clk) disable iff (reset)
        ticks.sub |=> !ticks.sub)
        else $error("ticks.sub held for more than one cycle");

    valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
        stamp.valid |=> !stamp.valid)
        else $error("stamp.valid held for more than one cycle");

    lost_one_cycle: assert property (@(posedge clk) disable iff (reset)
        sync.lost_strobe |=> !sync.lost_strobe)
        else $error("sync.lost_strobe held for more than one cycle");

    // outputs stay quiet while reset is held.
    quiet_in_reset: assert property (@(posedge clk)
        reset |-> (ticks == '0) && !stamp.valid && !sync.lost_strobe && !imu_clkin)
        else $error("outputs active during reset");

    lock_drop_with_strobe: assert property (@(posedge clk) disable iff (reset)
        $fell(sync.locked) |-> sync.lost_strobe)
        else $error("sync.locked fell without sync.lost_strobe");

endmodule

bind control_timing_top control_timing_props i_control_timing_props (.*);

/* test/control_timing_tb.sv */
`timescale 1ns/10ps

module control_timing_tb;

    import timing_cfg_pkg::*;
    import timing_types_pkg::*;

    localparam int frame_lag = frame_offset_default + 1;

    logic           clk;
    logic           reset;
    logic           clk_64khz;
    logic           imu_int_n;
    logic           imu_clkin;
    ctrl_ticks_t    ticks;
    frame_stamp_t   stamp;
    sync_status_t   sync;

    integer seed;
    int     shift;
    int     tick_idx;
    int     last_int_tick;
    int     last_frame_tick;
    bit     have_int;
    bit     have_frame;
    int     frames_since_int;
    int     subs_since_int;
    int     periods_checked;
    int     gap_frames;
    int     exp_frame;
    int     exp_sub;
    int     exp_lost;
    bit     prev_int_edge;
    bit     prev_frame;
    bit     prev_sub;
    realtime last_64k_rise;
    realtime last_imu_rise;
    bit     have_imu_rise;

    control_timing_top i_control_timing_top (
        .clk       (clk),
        .reset     (reset),
        .clk_64khz (clk_64khz),
        .imu_int_n (imu_int_n),
        .imu_clkin (imu_clkin),
        .ticks     (ticks),
        .stamp     (stamp),
        .sync      (sync)
    );

    always #20 clk = ~clk;
    always #320 clk_64khz = ~clk_64khz;

    task report_value_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task report_hang(input string msg);
        $display("The run stopped because %s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // returns 2 ns after the clk edge that shows the n-th new imu clock rise.
    task wait_imu_rises(input int n);
        int  seen;
        int  cycles;
        logic prev;
        seen   = 0;
        cycles = 0;
        prev   = imu_clkin;
        while (seen < n) begin
            @(posedge clk);
            cycles++;
            if (imu_clkin && !prev) begin
                seen++;
                cycles = 0;
            end
            prev = imu_clkin;
            if (cycles > 100) begin
                report_hang("imu_clkin stopped toggling");
            end
        end
        #2;
    endtask

    task pulse_int(input int high_edges);
        wait_imu_rises(high_edges);
        imu_int_n = 1'b0;
        wait_imu_rises(4);
        imu_int_n = 1'b1;
    endtask

    always @(posedge clk_64khz) begin
        last_64k_rise = $realtime;
    end

    always @(imu_clkin) begin
        if (!reset) begin
            assert ($realtime == last_64k_rise)
                else report_value_error("imu_clkin moved off a clk_64khz rising edge");
        end
    end

    always @(posedge imu_clkin) begin
        if (have_imu_rise) begin
            assert ($realtime - last_imu_rise == 1280.0)
                else report_value_error("imu_clkin is not half the clk_64khz rate");
        end
        have_imu_rise = 1'b1;
        last_imu_rise = $realtime;
    end

    // tick bookkeeping sees the DUT outputs before they update on this edge.
    always @(posedge clk) begin
        if (!reset) begin
            if (ticks.tick) begin
                tick_idx++;
            end
            if (ticks.int_edge) begin
                if (have_int && (tick_idx - last_int_tick == 32)) begin
                    assert (frames_since_int == 1 && subs_since_int == 3)
                        else report_value_error("wrong frame or subframe count in a period");
                    periods_checked++;
                end
                have_int         = 1'b1;
                last_int_tick    = tick_idx;
                frames_since_int = 0;
                subs_since_int   = 0;
            end
            if (ticks.frame) begin
                if (have_int) begin
                    assert (tick_idx - last_int_tick == frame_lag ||
                            (tick_idx - last_int_tick > frame_lag &&
                             (tick_idx - last_int_tick - frame_lag) % 64 == 0))
                        else report_value_error("frame strobe off its interrupt offset");
                    if (tick_idx - last_int_tick > frame_lag) begin
                        gap_frames++;
                    end
                end
                frames_since_int++;
                subs_since_int  = 0;
                last_frame_tick = tick_idx;
                have_frame      = 1'b1;
            end
            if (ticks.sub && !ticks.frame) begin
                if (have_frame) begin
                    assert ((tick_idx - last_frame_tick) % 8 == 0)
                        else report_value_error("subframe strobe off the 8-tick grid");
                end
                subs_since_int++;
            end

            assert (stamp.valid == (prev_frame || prev_sub))
                else report_value_error("stamp.valid does not follow a strobe");
            if (stamp.valid) begin
                assert (stamp.is_frame == prev_frame)
                    else report_value_error("stamp.is_frame wrong");
                if (prev_frame) begin
                    assert (stamp.frame_num == exp_frame[15:0] && stamp.sub_index == 3'd0)
                        else report_value_error("frame stamp number wrong");
                    exp_frame++;
                    exp_sub = 0;
                end else if (exp_frame > 0) begin
                    exp_sub++;
                    assert (stamp.sub_index == exp_sub[2:0] &&
                            stamp.frame_num == 16'(exp_frame - 1))
                        else report_value_error("subframe stamp index wrong");
                end
            end

            if (prev_int_edge) begin
                assert (sync.locked)
                    else report_value_error("locked not set after interrupt edge");
            end
            if (sync.lost_strobe) begin
                exp_lost++;
                assert (tick_idx - last_int_tick == sync_timeout_default)
                    else report_value_error("lost_strobe at the wrong tick");
                assert (sync.lost_count == exp_lost[7:0])
                    else report_value_error("lost_count wrong");
                assert (!sync.locked)
                    else report_value_error("locked still set with lost_strobe");
            end

            prev_int_edge = ticks.int_edge;
            prev_frame    = ticks.frame;
            prev_sub      = ticks.sub;
        end
    end

    initial begin
        clk           = 1'b0;
        clk_64khz     = 1'b0;
        reset         = 1'b1;
        imu_int_n     = 1'b1;
        seed          = 2764;
        tick_idx      = 0;
        have_int      = 1'b0;
        have_frame    = 1'b0;
        exp_frame     = 0;
        exp_sub       = 0;
        exp_lost      = 0;
        periods_checked = 0;
        gap_frames    = 0;
        have_imu_rise = 1'b0;
        last_64k_rise = 0.0;

        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        repeat (4) pulse_int(28);

        // interrupts missing for 60 edges.
        wait_imu_rises(60);
        repeat (3) pulse_int(28);

        shift = 1 + ($unsigned($random(seed)) % 7);
        pulse_int(28 + shift);
        repeat (4) pulse_int(28);
        wait_imu_rises(16);

        assert (periods_checked >= 6)
            else report_value_error("too few interrupt periods checked");
        assert (exp_lost == 1 && sync.lost_count == 8'd1)
            else report_value_error("expected exactly one lost-sync event");
        assert (gap_frames >= 1)
            else report_value_error("no free-running frame during the gap");
        assert (sync.locked)
            else report_value_error("sync not locked at the end");

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verilog.f */
hw/timing_cfg_pkg.sv
hw/timing_types_pkg.sv
hw/reset_sync.sv
hw/control_pulse_gen.sv
hw/imu_sync_monitor.sv
hw/frame_sequencer.sv
hw/control_timing_top.sv
test/control_timing_props.sv
test/control_timing_tb.sv
